//--- design/mem_pkg.sv
`default_nettype none

package mem_pkg;

	// Byte address and data word widths.
	localparam int addr_width = 64;
	localparam int data_width = 64;

	// Memory operations seen by the access unit.
	typedef enum logic [2:0] {
		IS_NONE       = 3'd0,
		IS_LDQ_INST   = 3'd1, // Plain load.
		IS_LDL_INST   = 3'd2, // Load-locked.
		IS_STQ_INST   = 3'd3, // Plain store.
		IS_STQ_C_INST = 3'd4  // Store-conditional.
	} mem_inst_type_t;

	// True for operations that read the data memory.
	function automatic logic is_load(input mem_inst_type_t op);
		return (op == IS_LDQ_INST) || (op == IS_LDL_INST);
	endfunction

endpackage

`default_nettype wire

//--- design/llsc_table.sv
`default_nettype none

module llsc_table import mem_pkg::*; #(
	parameter int llsc_size = 4
) (
	input  logic                  clock,
	input  logic                  reset,
	input  mem_inst_type_t        mem_inst_type,
	input  logic [addr_width-1:0] mem_addr,
	output logic                  store_success,
	output logic                  full
);

	logic [addr_width-1:0] address_tag [llsc_size];
	logic [llsc_size-1:0]  valid;
	logic [llsc_size-1:0]  good;

	logic [addr_width-1:0] next_address_tag [llsc_size];
	logic [llsc_size-1:0]  next_valid;
	logic [llsc_size-1:0]  next_good;

	logic [llsc_size-1:0]  match;     // Valid entry holding mem_addr.
	logic [llsc_size-1:0]  first_hit; // Lowest matching entry only.
	logic [llsc_size-1:0]  first_free;
	logic                  any_hit;

	// Entry flags.
	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
			good  <= '0;
		end else begin
			valid <= next_valid;
			good  <= next_good;
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < llsc_size; i++) begin
			address_tag[i] <= next_address_tag[i];
		end
	end

	// Address compare and priority picks.
	always_comb begin
		logic seen_hit;
		logic seen_free;
		seen_hit   = 1'b0;
		seen_free  = 1'b0;
		first_hit  = '0;
		first_free = '0;
		for (int i = 0; i < llsc_size; i++) begin
			match[i] = valid[i] && (address_tag[i] == mem_addr);
			if (match[i] && !seen_hit) begin
				first_hit[i] = 1'b1;
				seen_hit     = 1'b1;
			end
			if (!valid[i] && !seen_free) begin
				first_free[i] = 1'b1;
				seen_free     = 1'b1;
			end
		end
		any_hit = seen_hit;
	end

	always_comb begin
		store_success = 1'b0;
		next_valid    = valid;
		next_good     = good;
		for (int i = 0; i < llsc_size; i++) begin
			next_address_tag[i] = address_tag[i];
		end

		case (mem_inst_type)
			IS_LDL_INST: begin
				if (any_hit) begin
					// Re-lock of a held address loses the reservation.
					next_good = good & ~first_hit;
				end else begin
					// Claim the first free slot if there is one.
					for (int i = 0; i < llsc_size; i++) begin
						if (first_free[i]) begin
							next_address_tag[i] = mem_addr;
							next_valid[i]       = 1'b1;
							next_good[i]        = 1'b1;
						end
					end
				end
			end
			IS_STQ_C_INST: begin
				// Entry is released whatever the outcome.
				next_valid    = valid & ~first_hit;
				store_success = |(first_hit & good);
			end
			IS_STQ_INST: begin
				next_good = good & ~first_hit;
			end
			default: ;
		endcase
	end

	assign full = &valid;

endmodule

`default_nettype wire

//--- design/data_memory.sv
`default_nettype none

module data_memory import mem_pkg::*; #(
	parameter int mem_words = 64
) (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         read,
	input  logic                         write,
	input  logic [$clog2(mem_words)-1:0] index,
	input  logic [data_width-1:0]        wdata,
	output logic [data_width-1:0]        rdata
);

	logic [data_width-1:0] mem [mem_words];

	// Contents start at zero after reset.
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < mem_words; i++) begin
				mem[i] <= '0;
			end
		end else if (write) begin
			mem[index] <= wdata;
		end
	end

	// Read word is held until the next read.
	always_ff @(posedge clock) begin
		if (read) begin
			rdata <= mem[index];
		end
	end

endmodule

`default_nettype wire

//--- design/mem_access_ctrl.sv
`default_nettype none

module mem_access_ctrl import mem_pkg::*; #(
	parameter int mem_words = 64
) (
	input  logic                         clock,
	input  logic                         reset,

	input  logic                         req_valid,
	input  mem_inst_type_t               req_op,
	input  logic [addr_width-1:0]        req_addr,
	input  logic [data_width-1:0]        req_data,
	output logic                         req_ready,

	output logic                         resp_valid,
	input  logic                         resp_ready,
	output logic [data_width-1:0]        resp_data,

	output mem_inst_type_t               llsc_op,
	output logic [addr_width-1:0]        llsc_addr,
	input  logic                         store_success,

	output logic                         mem_read,
	output logic                         mem_write,
	output logic [$clog2(mem_words)-1:0] mem_index,
	output logic [data_width-1:0]        mem_wdata,
	input  logic [data_width-1:0]        mem_rdata
);

	localparam int index_w = $clog2(mem_words);

	logic accept;
	logic sc_op;
	logic resp_is_load; // Response comes from the memory read port.
	logic resp_sc_ok;

	// Free slot, or the held response leaves this cycle.
	assign req_ready = !resp_valid || resp_ready;
	assign accept    = req_valid && req_ready;
	assign sc_op     = (req_op == IS_STQ_C_INST);

	// Table only sees accepted requests.
	assign llsc_op   = accept ? req_op : IS_NONE;
	assign llsc_addr = req_addr;

	assign mem_read  = accept && is_load(req_op);
	assign mem_write = accept && ((req_op == IS_STQ_INST) || (sc_op && store_success));
	assign mem_index = req_addr[3 +: index_w]; // Word select from byte address.
	assign mem_wdata = req_data;

	always_ff @(posedge clock) begin
		if (reset) begin
			resp_valid   <= 1'b0;
			resp_is_load <= 1'b0;
		end else if (accept) begin
			resp_valid   <= 1'b1;
			resp_is_load <= is_load(req_op);
		end else if (resp_ready) begin
			resp_valid   <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			resp_sc_ok <= sc_op && store_success;
		end
	end

	// Plain stores report zero.
	assign resp_data = resp_is_load ? mem_rdata : {{(data_width-1){1'b0}}, resp_sc_ok};

endmodule

`default_nettype wire

//--- design/mem_unit.sv
`default_nettype none

module mem_unit import mem_pkg::*; #(
	parameter int llsc_size = 4,
	parameter int mem_words = 64
) (
	input  logic                  clock,
	input  logic                  reset,

	input  logic                  req_valid,
	input  mem_inst_type_t        req_op,
	input  logic [addr_width-1:0] req_addr,
	input  logic [data_width-1:0] req_data,
	output logic                  req_ready,

	output logic                  resp_valid,
	input  logic                  resp_ready,
	output logic [data_width-1:0] resp_data,

	output logic                  llsc_full
);

	localparam int index_w = $clog2(mem_words);

	mem_inst_type_t        llsc_op;
	logic [addr_width-1:0] llsc_addr;
	logic                  store_success;

	logic                  mem_read;
	logic                  mem_write;
	logic [index_w-1:0]    mem_index;
	logic [data_width-1:0] mem_wdata;
	logic [data_width-1:0] mem_rdata;

	mem_access_ctrl #(
		.mem_words(mem_words)
	) i_ctrl (
		.clock        (clock),
		.reset        (reset),
		.req_valid    (req_valid),
		.req_op       (req_op),
		.req_addr     (req_addr),
		.req_data     (req_data),
		.req_ready    (req_ready),
		.resp_valid   (resp_valid),
		.resp_ready   (resp_ready),
		.resp_data    (resp_data),
		.llsc_op      (llsc_op),
		.llsc_addr    (llsc_addr),
		.store_success(store_success),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.mem_index    (mem_index),
		.mem_wdata    (mem_wdata),
		.mem_rdata    (mem_rdata)
	);

	llsc_table #(
		.llsc_size(llsc_size)
	) i_llsc (
		.clock        (clock),
		.reset        (reset),
		.mem_inst_type(llsc_op),
		.mem_addr     (llsc_addr),
		.store_success(store_success),
		.full         (llsc_full)
	);

	data_memory #(
		.mem_words(mem_words)
	) i_dmem (
		.clock(clock),
		.reset(reset),
		.read (mem_read),
		.write(mem_write),
		.index(mem_index),
		.wdata(mem_wdata),
		.rdata(mem_rdata)
	);

endmodule

`default_nettype wire

//--- tb/clock_gen.sv
`default_nettype none

module clock_gen #(
	parameter int period       = 8,
	parameter int reset_cycles = 16
) (
	output logic clock,
	output logic reset
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	// Released just after an edge, like the other inputs.
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		#1 reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- tb/mem_unit_properties.sv
`default_nettype none

module mem_unit_properties import mem_pkg::*; (
	input logic                  clock,
	input logic                  reset,
	input logic                  req_valid,
	input logic                  req_ready,
	input logic                  resp_valid,
	input logic                  resp_ready,
	input logic [data_width-1:0] resp_data,
	input logic                  llsc_full
);

	timeunit 1ns;
	timeprecision 100ps;

	int unsigned fail_count = 0;

	// A stalled response keeps its value.
	resp_hold: assert property (@(posedge clock) disable iff (reset)
		resp_valid && !resp_ready |=> resp_valid && $stable(resp_data))
	else begin
		$error("response changed while it was stalled");
		fail_count++;
	end

	resp_stall_blocks_req: assert property (@(posedge clock) disable iff (reset)
		resp_valid && !resp_ready |-> !req_ready)
	else begin
		$error("request port ready while a stalled response is held");
		fail_count++;
	end

	reset_state: assert property (@(posedge clock)
		$fell(reset) |-> !resp_valid && !llsc_full)
	else begin
		$error("response valid or table full right after reset");
		fail_count++;
	end

	accept_to_resp: assert property (@(posedge clock) disable iff (reset)
		req_valid && req_ready |=> resp_valid)
	else begin
		$error("no response one cycle after an accepted request");
		fail_count++;
	end

endmodule

`default_nettype wire

//--- tb/tb_mem_unit.sv
`default_nettype none

module tb_mem_unit import mem_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int llsc_size      = 4; // DUT defaults.
	localparam int mem_words      = 64;
	localparam int index_w        = $clog2(mem_words);
	localparam int timeout_cycles = 6000;

	logic                  clock;
	logic                  reset;
	logic                  req_valid;
	mem_inst_type_t        req_op;
	logic [addr_width-1:0] req_addr;
	logic [data_width-1:0] req_data;
	logic                  req_ready;
	logic                  resp_valid;
	logic                  resp_ready;
	logic [data_width-1:0] resp_data;
	logic                  llsc_full;

	// Reference model.
	logic [data_width-1:0] model_mem [mem_words];
	logic [addr_width-1:0] res_addr [llsc_size];
	logic [llsc_size-1:0]  res_valid;
	logic [llsc_size-1:0]  res_good;

	logic [data_width-1:0] expected_q [$];
	string                 name_q [$];
	string                 test_name;
	int                    value_errors;
	int                    flag_errors;
	int                    cycles;
	integer                seed;
	logic                  random_ready;
	logic                  ready_next;

	clock_gen #(.period(8), .reset_cycles(16)) i_clock_gen (.clock(clock), .reset(reset));

	mem_unit #(
		.llsc_size(llsc_size),
		.mem_words(mem_words)
	) i_mem_unit (
		.clock     (clock),
		.reset     (reset),
		.req_valid (req_valid),
		.req_op    (req_op),
		.req_addr  (req_addr),
		.req_data  (req_data),
		.req_ready (req_ready),
		.resp_valid(resp_valid),
		.resp_ready(resp_ready),
		.resp_data (resp_data),
		.llsc_full (llsc_full)
	);

	bind mem_unit mem_unit_properties i_props (
		.clock     (clock),
		.reset     (reset),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.resp_valid(resp_valid),
		.resp_ready(resp_ready),
		.resp_data (resp_data),
		.llsc_full (llsc_full)
	);

	// Applies one accepted request to the model, returns its response.
	task automatic model_request(input mem_inst_type_t op, input logic [addr_width-1:0] addr,
		input logic [data_width-1:0] data, output logic [data_width-1:0] result);
		int                 hit;
		int                 free;
		logic [index_w-1:0] idx;
		idx  = addr[3 +: index_w];
		hit  = -1;
		free = -1;
		for (int i = llsc_size - 1; i >= 0; i--) begin
			if (res_valid[i] && res_addr[i] == addr) hit = i;
			if (!res_valid[i]) free = i; // Lowest free entry wins.
		end
		result = '0;
		case (op)
			IS_LDQ_INST: result = model_mem[idx];
			IS_LDL_INST: begin
				result = model_mem[idx];
				if (hit >= 0) begin
					res_good[hit] = 1'b0;
				end else if (free >= 0) begin
					res_addr[free]  = addr;
					res_valid[free] = 1'b1;
					res_good[free]  = 1'b1;
				end
			end
			IS_STQ_INST: begin
				model_mem[idx] = data;
				if (hit >= 0) res_good[hit] = 1'b0;
			end
			IS_STQ_C_INST: begin
				if (hit >= 0) begin
					result[0]      = res_good[hit];
					res_valid[hit] = 1'b0;
				end
				if (result[0]) model_mem[idx] = data;
			end
			default: ;
		endcase
	endtask

	// Holds one request until the DUT takes it.
	task automatic send(input mem_inst_type_t op, input logic [addr_width-1:0] addr,
		input logic [data_width-1:0] data);
		logic taken;
		req_valid = 1'b1;
		req_op    = op;
		req_addr  = addr;
		req_data  = data;
		taken     = 1'b0;
		while (!taken) begin
			@(negedge clock);
			taken = req_ready;
			@(posedge clock);
			#1;
		end
		req_valid = 1'b0;
		req_op    = IS_NONE;
	endtask

	task automatic drain();
		while (expected_q.size() != 0 || resp_valid) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic check_full(input logic expected);
		@(negedge clock);
		assert (llsc_full == expected) else begin
			$display("CHECK FAILED %s: llsc_full expected %0b actual %0b",
				test_name, expected, llsc_full);
			flag_errors++;
		end
		@(posedge clock);
		#1;
	endtask

	// Samples mid-cycle, ahead of the edge that consumes or accepts.
	always @(negedge clock) begin
		logic [data_width-1:0] expected;
		logic [data_width-1:0] result;
		string                 name;
		if (!reset) begin
			assert (llsc_full == &res_valid) else begin
				$display("CHECK FAILED %s: llsc_full expected %0b actual %0b",
					test_name, &res_valid, llsc_full);
				flag_errors++;
			end
			if (resp_valid && resp_ready) begin
				if (expected_q.size() == 0) begin
					$display("A response came out with no request outstanding");
					value_errors++;
				end else begin
					expected = expected_q.pop_front();
					name     = name_q.pop_front();
					assert (resp_data == expected) else begin
						$display("CHECK FAILED %s: expected %h actual %h",
							name, expected, resp_data);
						value_errors++;
					end
				end
			end
			if (req_valid && req_ready) begin
				model_request(req_op, req_addr, req_data, result);
				expected_q.push_back(result);
				name_q.push_back(test_name);
			end
		end
	end

	// Random back-pressure, drawn at the falling edge.
	always @(negedge clock) begin
		logic [31:0] rnd;
		if (random_ready) begin
			rnd        = $random(seed);
			ready_next = rnd[0];
		end
	end

	always @(posedge clock) begin
		#1;
		if (random_ready) resp_ready = ready_next;
	end

	initial begin
		cycles = 0;
		while (cycles < timeout_cycles) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		logic [31:0]           rnd;
		logic [addr_width-1:0] addr;
		logic [data_width-1:0] data;
		int unsigned           prop_errors;
		mem_inst_type_t        op;
		seed         = 32'hb74e;
		req_valid    = 1'b0;
		req_op       = IS_NONE;
		req_addr     = '0;
		req_data     = '0;
		resp_ready   = 1'b1;
		random_ready = 1'b0;
		ready_next   = 1'b1;
		value_errors = 0;
		flag_errors  = 0;
		test_name    = "reset";
		res_valid    = '0;
		res_good     = '0;
		for (int i = 0; i < mem_words; i++) model_mem[i] = '0;
		for (int i = 0; i < llsc_size; i++) res_addr[i] = '0;
		wait (reset === 1'b0);
		@(posedge clock);
		#1;

		test_name = "load_store";
		for (int n = 0; n < 150; n++) begin
			rnd  = $random(seed);
			addr = {{(addr_width-7){1'b0}}, rnd[7:4], 3'b000}; // 16 words.
			data = {$random(seed), $random(seed)};
			send(rnd[0] ? IS_STQ_INST : IS_LDQ_INST, addr, data);
		end
		drain();

		test_name = "ll_sc_success";
		send(IS_LDL_INST, 64'h100, '0);
		send(IS_STQ_C_INST, 64'h100, 64'hcafe_f00d_1234_5678);
		send(IS_LDQ_INST, 64'h100, '0);
		drain();

		test_name = "ll_sc_broken";
		send(IS_LDL_INST, 64'h108, '0);
		send(IS_STQ_INST, 64'h108, 64'h1111_2222_3333_4444);
		send(IS_STQ_C_INST, 64'h108, 64'h5555_6666_7777_8888);
		send(IS_LDQ_INST, 64'h108, '0);
		send(IS_STQ_C_INST, 64'h110, 64'h0bad_0bad_0bad_0bad); // No reservation.
		send(IS_LDQ_INST, 64'h110, '0);
		send(IS_LDL_INST, 64'h118, '0);
		send(IS_STQ_C_INST, 64'h118, 64'h0000_0000_0000_00aa);
		send(IS_STQ_C_INST, 64'h118, 64'h0000_0000_0000_00bb);
		send(IS_LDQ_INST, 64'h118, '0);
		drain();

		test_name = "llsc_full";
		send(IS_LDL_INST, 64'h120, '0);
		send(IS_LDL_INST, 64'h128, '0);
		send(IS_LDL_INST, 64'h130, '0);
		send(IS_LDL_INST, 64'h8000_0000_0000_0120, '0); // Same word, other address.
		drain();
		check_full(1'b1);
		send(IS_LDL_INST, 64'h138, '0);
		send(IS_STQ_C_INST, 64'h138, 64'h0000_0000_0000_0138);
		send(IS_STQ_C_INST, 64'h120, 64'h0000_0000_0000_0120);
		drain();
		check_full(1'b0);

		test_name    = "backpressure";
		random_ready = 1'b1;
		for (int n = 0; n < 200; n++) begin
			rnd  = $random(seed);
			addr = {{(addr_width-6){1'b0}}, rnd[6:4], 3'b000}; // 8 words.
			data = {$random(seed), $random(seed)};
			case (rnd[1:0])
				2'd0:    op = IS_LDQ_INST;
				2'd1:    op = IS_LDL_INST;
				2'd2:    op = IS_STQ_INST;
				default: op = IS_STQ_C_INST;
			endcase
			send(op, addr, data);
		end
		drain();
		random_ready = 1'b0;
		resp_ready   = 1'b1;
		repeat (4) @(posedge clock);

		prop_errors = i_mem_unit.i_props.fail_count;
		$display("Errors: %0d response, %0d flag, %0d protocol",
			value_errors, flag_errors, prop_errors);
		if (value_errors == 0 && flag_errors == 0 && prop_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
design/mem_pkg.sv
design/llsc_table.sv
design/data_memory.sv
design/mem_access_ctrl.sv
design/mem_unit.sv
tb/clock_gen.sv
tb/mem_unit_properties.sv
tb/tb_mem_unit.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it once.
# The run passes only if the pass line shows up in the output.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_unit -f filelist.f &&
./obj_dir/Vtb_mem_unit +verilator+error+limit+1000 | tee /dev/stderr |
	grep -q "ALL TESTS PASSED" &&
echo "Simulation passed." ||
{
	echo "Simulation failed."
	exit 1
}
